//--- flist.f
verilog/pio_mem_pkg.sv
verilog/ram_dual_we_bram.sv
verilog/pio_rw_dmem_bram.sv
verilog/pio_host_bridge.sv
verilog/lookup_engine.sv
verilog/pio_mem_subsys_top.sv
verif/pio_mem_checker.sv
verif/tb_pio_mem.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the PIO lookup table testbench.
# The result is read back from the simulation log.
verilator --binary -Wno-fatal -f flist.f --top-module tb_pio_mem \
	-Mdir obj_dir -o sim_pio_mem > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_pio_mem > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -qx "Simulation passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- verif/tb_pio_mem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the PIO lookup table.
// Runs a table of host and lookup operations
// with background lookups on port B.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_pio_mem
	import pio_mem_pkg::*;
();

	localparam int PIO_DIV = 4;
	localparam int LKP_CREDITS = 4;
	localparam logic [1:0] L_NONE = 2'd0;
	localparam logic [1:0] L_LOOKUP = 2'd1;
	localparam logic [1:0] L_LEARN = 2'd2;

	// One table row.
	// Host data is write data, or the expected word of a read.
	typedef struct packed {
		logic       h_en;
		logic       h_wr;
		logic       h_bad;
		tbl_index_t h_idx;
		pio_word_t  h_data;
		logic [1:0] l_op;
		tbl_index_t l_idx;
		tbl_data_t  l_data;
		tbl_be_t    l_be;
		logic [3:0] bg;
	} step_t;

	logic        clk;
	logic        rst_n;
	logic        host_req_valid;
	host_req_t   host_req;
	logic        host_req_ready;
	logic        host_rsp_valid;
	host_rsp_t   host_rsp;
	logic        lkp_req_valid;
	lkp_req_t    lkp_req;
	logic        lkp_credit;
	logic        lkp_rsp_valid;
	lkp_rsp_t    lkp_rsp;
	pio_word_t   exp_data;
	logic        done;
	int          host_errs;
	int          lkp_errs;
	int          proto_errs;
	step_t       steps [$];
	logic        table_ready;
	logic [15:0] lfsr;
	int          credits;

	pio_mem_subsys_top #(
		.WIDTH(TBL_WIDTH),
		.DEPTH_NBITS(TBL_DEPTH_NBITS),
		.PIO_DIV(PIO_DIV),
		.LKP_CREDITS(LKP_CREDITS)
	) dut (
		.clk(clk),
		.rst_n(rst_n),
		.host_req_valid(host_req_valid),
		.host_req(host_req),
		.host_req_ready(host_req_ready),
		.host_rsp_valid(host_rsp_valid),
		.host_rsp(host_rsp),
		.lkp_req_valid(lkp_req_valid),
		.lkp_req(lkp_req),
		.lkp_credit(lkp_credit),
		.lkp_rsp_valid(lkp_rsp_valid),
		.lkp_rsp(lkp_rsp)
	);

	pio_mem_checker #(
		.LKP_CREDITS(LKP_CREDITS)
	) chk (
		.clk(clk),
		.rst_n(rst_n),
		.host_req_valid(host_req_valid),
		.host_req_ready(host_req_ready),
		.host_req(host_req),
		.host_rsp_valid(host_rsp_valid),
		.host_rsp(host_rsp),
		.lkp_req_valid(lkp_req_valid),
		.lkp_req(lkp_req),
		.lkp_credit(lkp_credit),
		.lkp_rsp_valid(lkp_rsp_valid),
		.lkp_rsp(lkp_rsp),
		.exp_data(exp_data),
		.done(done),
		.host_errs(host_errs),
		.lkp_errs(lkp_errs),
		.proto_errs(proto_errs)
	);

	always #50 clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Helpers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1.
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	// Four bits, so background lookups stay in 0..15.
	task automatic draw_index(output tbl_index_t idx);
		idx = '0;
		for (int i = 0; i < 4; i++) begin
			lfsr = lfsr_step(lfsr);
			idx = {idx[TBL_DEPTH_NBITS-2:0], lfsr[0]};
		end
	endtask

	// Preload word, differs for every index.
	function automatic tbl_data_t fill_word(input tbl_index_t idx);
		return {6'h2b, idx, ~idx, 6'h15};
	endfunction

	// Byte address of an entry, region bumped when bad.
	function automatic pio_word_t host_addr(input tbl_index_t idx, input logic bad);
		logic [15:0] region;
		region = bad ? MEM_REGION + 16'h0001 : MEM_REGION;
		return {region, 4'h0, idx, 2'b00};
	endfunction

	function automatic step_t row(input logic h_en, input logic h_wr, input logic h_bad,
			input int h_idx, input pio_word_t h_data, input logic [1:0] l_op,
			input int l_idx, input tbl_data_t l_data, input tbl_be_t l_be, input int bg);
		step_t s;
		s.h_en = h_en;
		s.h_wr = h_wr;
		s.h_bad = h_bad;
		s.h_idx = tbl_index_t'(h_idx);
		s.h_data = h_data;
		s.l_op = l_op;
		s.l_idx = tbl_index_t'(l_idx);
		s.l_data = l_data;
		s.l_be = l_be;
		s.bg = 4'(bg);
		return s;
	endfunction

	task automatic build_table();
		// Full-word learns fill 0..31.
		for (int i = 0; i < 32; i++) begin
			steps.push_back(row(0, 0, 0, 0, '0, L_LEARN, i, fill_word(tbl_index_t'(i)),
				4'hf, 0));
		end
		// Host write and read back.
		steps.push_back(row(1, 1, 0, 64, 32'h1111_2222, L_NONE, 0, '0, '0, 0));
		steps.push_back(row(1, 1, 0, 65, 32'hcafe_f00d, L_LOOKUP, 3, '0, '0, 0));
		steps.push_back(row(1, 0, 0, 64, 32'h1111_2222, L_NONE, 0, '0, '0, 0));
		steps.push_back(row(1, 0, 0, 65, 32'hcafe_f00d, L_NONE, 0, '0, '0, 0));
		// Out of region write and read, target left as it was.
		steps.push_back(row(1, 1, 1, 64, 32'hdead_beef, L_NONE, 0, '0, '0, 0));
		steps.push_back(row(1, 0, 1, 64, 32'h0, L_NONE, 0, '0, '0, 0));
		steps.push_back(row(1, 0, 0, 64, 32'h1111_2222, L_NONE, 0, '0, '0, 0));
		// Partial learns, then a lookup of the same entry.
		steps.push_back(row(0, 0, 0, 0, '0, L_LEARN, 16, 32'haabb_ccdd, 4'b0101, 0));
		steps.push_back(row(0, 0, 0, 0, '0, L_LOOKUP, 16, '0, '0, 0));
		steps.push_back(row(0, 0, 0, 0, '0, L_LEARN, 17, 32'h1234_5678, 4'b1000, 2));
		steps.push_back(row(0, 0, 0, 0, '0, L_LOOKUP, 17, '0, '0, 0));
		// Host traffic against back-to-back lookups.
		steps.push_back(row(1, 0, 0, 3, fill_word(10'd3), L_LOOKUP, 16, '0, '0, 8));
		steps.push_back(row(1, 0, 0, 65, 32'hcafe_f00d, L_NONE, 0, '0, '0, 8));
		steps.push_back(row(1, 1, 0, 66, 32'h0bad_cafe, L_LOOKUP, 17, '0, '0, 6));
		steps.push_back(row(1, 0, 0, 66, 32'h0bad_cafe, L_NONE, 0, '0, '0, 6));
		steps.push_back(row(1, 0, 0, 10, fill_word(10'd10), L_LOOKUP, 12, '0, '0, 15));
	endtask

	task automatic send_lookup(input logic learn, input tbl_index_t idx,
			input tbl_data_t data, input tbl_be_t be);
		lkp_req.index <= idx;
		lkp_req.learn <= learn;
		lkp_req.data <= data;
		lkp_req.be <= be;
		lkp_req_valid <= 1'b1;
		credits--;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// One table row, one clock edge per pass.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic run_step(input step_t s);
		logic       started;
		logic       host_done;
		logic       lkp_sent;
		int         bg_left;
		tbl_index_t ridx;
		started = 1'b0;
		host_done = ~s.h_en;
		lkp_sent = (s.l_op == L_NONE);
		bg_left = s.bg;
		while (!(host_done && lkp_sent && bg_left == 0)) begin
			@(posedge clk);
			if (lkp_credit) begin
				credits++;
			end
			if (host_rsp_valid) begin
				host_done = 1'b1;
			end
			// Handshake on this edge.
			if (host_req_valid && host_req_ready) begin
				host_req_valid <= 1'b0;
			end
			if (!started && s.h_en) begin
				host_req.addr <= host_addr(s.h_idx, s.h_bad);
				host_req.wdata <= s.h_wr ? s.h_data : '0;
				host_req.write <= s.h_wr;
				host_req_valid <= 1'b1;
				exp_data <= s.h_data;
			end
			started = 1'b1;
			lkp_req_valid <= 1'b0;
			// Table lookup first, then background ones.
			if (credits > 0 && !lkp_sent) begin
				send_lookup(s.l_op == L_LEARN, s.l_idx, s.l_data, s.l_be);
				lkp_sent = 1'b1;
			end else if (credits > 0 && bg_left > 0) begin
				draw_index(ridx);
				send_lookup(1'b0, ridx, '0, '0);
				bg_left--;
			end
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Main sequence.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		host_req_valid = 1'b0;
		host_req = '0;
		lkp_req_valid = 1'b0;
		lkp_req = '0;
		exp_data = '0;
		done = 1'b0;
		table_ready = 1'b0;
		lfsr = 16'd56886;
		credits = LKP_CREDITS;
		build_table();
		table_ready = 1'b1;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < steps.size(); i++) begin
			run_step(steps[i]);
		end
		// Drain until every credit is back.
		while (credits != LKP_CREDITS) begin
			@(posedge clk);
			lkp_req_valid <= 1'b0;
			if (lkp_credit) begin
				credits++;
			end
		end
		repeat (4) @(posedge clk);
		done <= 1'b1;
		repeat (2) @(posedge clk);
		$display("errors: host %0d, lookup %0d, protocol %0d", host_errs, lkp_errs,
			proto_errs);
		if (host_errs + lkp_errs + proto_errs == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// Watchdog, sized from the table.
	initial begin
		wait (table_ready);
		repeat (steps.size() * 40 + 200) @(posedge clk);
		$display("timeout: the stimulus table did not finish in %0d cycles",
			steps.size() * 40 + 200);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/pio_mem_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scoreboard for the PIO lookup table.
// Shadow table, expected response queues
// and credit accounting.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module pio_mem_checker
	import pio_mem_pkg::*;
#(
	parameter int LKP_CREDITS = 4
) (
	input  wire             clk,
	input  wire             rst_n,
	input  wire             host_req_valid,
	input  wire             host_req_ready,
	input  wire  host_req_t host_req,
	input  wire             host_rsp_valid,
	input  wire  host_rsp_t host_rsp,
	input  wire             lkp_req_valid,
	input  wire  lkp_req_t  lkp_req,
	input  wire             lkp_credit,
	input  wire             lkp_rsp_valid,
	input  wire  lkp_rsp_t  lkp_rsp,
	// Table value for the host read being issued.
	input  wire  pio_word_t exp_data,
	input  wire             done,
	output int              host_errs,
	output int              lkp_errs,
	output int              proto_errs
);

	// One expected host response.
	typedef struct packed {
		pio_word_t rdata;
		logic      err;
		pio_word_t tbl;
		logic      use_tbl;
	} host_exp_t;

	tbl_data_t shadow [0:(1<<TBL_DEPTH_NBITS)-1];
	host_exp_t host_q [$];
	lkp_rsp_t  lkp_q [$];
	logic      seen_req = 1'b0;
	logic      final_done = 1'b0;
	int        outstanding = 0;
	int        reqs_sent = 0;
	int        lookups_sent = 0;
	int        credits_seen = 0;
	int        rsps_seen = 0;
	int        n_host = 0;
	int        n_lkp = 0;
	int        n_proto = 0;

	assign host_errs = n_host;
	assign lkp_errs = n_lkp;
	assign proto_errs = n_proto;

	always @(posedge clk) begin
		host_exp_t  he;
		lkp_rsp_t   le;
		tbl_index_t idx;
		if (!rst_n && host_req_ready) begin
			n_proto++;
			$display("host_req_ready is high during reset");
		end
		// Quiet until the first request.
		if (!seen_req && (host_rsp_valid || lkp_rsp_valid || lkp_credit)) begin
			n_proto++;
			$display("a response or credit pulse came before any request");
		end

		// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
		// Host side.
		// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
		if (host_req_valid && host_req_ready) begin
			seen_req = 1'b1;
			idx = host_req.addr[TBL_DEPTH_NBITS+1:2];
			he = '0;
			if (host_req.addr[PIO_NBITS-1:16] != MEM_REGION) begin
				he.err = 1'b1;
			end else if (host_req.write) begin
				shadow[idx] = host_req.wdata;
			end else begin
				he.rdata = shadow[idx];
				he.tbl = exp_data;
				he.use_tbl = 1'b1;
			end
			host_q.push_back(he);
		end
		if (host_rsp_valid) begin
			if (host_q.size() == 0) begin
				n_proto++;
				$display("host response arrived with no request outstanding");
			end else begin
				he = host_q.pop_front();
				if (host_rsp.err !== he.err) begin
					n_host++;
					$display("error: host_rsp.err %h, expected %h", host_rsp.err, he.err);
				end
				if (host_rsp.rdata !== he.rdata) begin
					n_host++;
					$display("error: host_rsp.rdata %h, expected %h from shadow",
						host_rsp.rdata, he.rdata);
				end
				if (he.use_tbl && host_rsp.rdata !== he.tbl) begin
					n_host++;
					$display("error: host_rsp.rdata %h, expected %h from table",
						host_rsp.rdata, he.tbl);
				end
			end
		end

		// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
		// Lookup side.
		// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
		if (lkp_req_valid) begin
			seen_req = 1'b1;
			reqs_sent++;
			if (lkp_req.learn) begin
				// Byte merge into the shadow.
				for (int b = 0; b < TBL_WIDTH/8; b++) begin
					if (lkp_req.be[b]) begin
						shadow[lkp_req.index][b*8 +: 8] = lkp_req.data[b*8 +: 8];
					end
				end
			end else begin
				lookups_sent++;
				le.index = lkp_req.index;
				le.data = shadow[lkp_req.index];
				lkp_q.push_back(le);
			end
		end
		if (lkp_credit) begin
			credits_seen++;
		end
		outstanding += (lkp_req_valid ? 1 : 0) - (lkp_credit ? 1 : 0);
		if (outstanding > LKP_CREDITS || outstanding < 0) begin
			n_proto++;
			$display("lookup requests outstanding out of range, now %0d", outstanding);
		end
		if (lkp_rsp_valid) begin
			rsps_seen++;
			if (lkp_q.size() == 0) begin
				n_proto++;
				$display("lookup response arrived with no lookup outstanding");
			end else begin
				le = lkp_q.pop_front();
				if (lkp_rsp.index !== le.index) begin
					n_lkp++;
					$display("error: lkp_rsp.index %h, expected %h", lkp_rsp.index, le.index);
				end
				if (lkp_rsp.data !== le.data) begin
					n_lkp++;
					$display("error: lkp_rsp.data %h, expected %h", lkp_rsp.data, le.data);
				end
			end
		end

		// End of run totals.
		if (done && !final_done) begin
			final_done = 1'b1;
			if (credits_seen != reqs_sent) begin
				n_proto++;
				$display("%0d credit pulses for %0d requests", credits_seen, reqs_sent);
			end
			if (rsps_seen != lookups_sent) begin
				n_proto++;
				$display("%0d lookup responses for %0d lookups", rsps_seen, lookups_sent);
			end
			if (host_q.size() != 0 || lkp_q.size() != 0) begin
				n_proto++;
				$display("responses still missing at the end of the run");
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/pio_mem_subsys_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PIO lookup table subsystem.
// Host bridge, lookup engine and the shared
// dual-port table memory.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module pio_mem_subsys_top
	import pio_mem_pkg::*;
#(
	parameter int WIDTH = TBL_WIDTH,
	parameter int DEPTH_NBITS = TBL_DEPTH_NBITS,
	parameter int PIO_DIV = 4,
	parameter int LKP_CREDITS = 4
) (
	input  wire             clk,
	input  wire             rst_n,

	// Host side.
	input  wire             host_req_valid,
	input  wire  host_req_t host_req,
	output logic            host_req_ready,
	output logic            host_rsp_valid,
	output host_rsp_t       host_rsp,

	// Lookup side.
	input  wire             lkp_req_valid,
	input  wire  lkp_req_t  lkp_req,
	output logic            lkp_credit,
	output logic            lkp_rsp_valid,
	output lkp_rsp_t        lkp_rsp
);

	// PIO bus.
	logic                   clk_div;
	pio_word_t              reg_addr;
	pio_word_t              reg_din;
	logic                   reg_rd;
	logic                   reg_wr;
	logic                   reg_ms;
	logic                   mem_ack;
	pio_word_t              mem_rdata;

	// Engine to memory.
	logic                   app_mem_rd;
	logic [DEPTH_NBITS-1:0] addrb;
	logic [WIDTH-1:0]       doutb;
	logic [3:0]             wea;
	logic [DEPTH_NBITS-1:0] addra;
	logic [WIDTH-1:0]       dina;

	// Engine never writes port B.
	logic [3:0]             web;
	logic [WIDTH-1:0]       dinb;

	assign web = '0;
	assign dinb = '0;

	pio_host_bridge #(
		.PIO_DIV(PIO_DIV)
	) u_bridge (
		.clk(clk),
		.rst_n(rst_n),
		.host_req_valid(host_req_valid),
		.host_req(host_req),
		.host_req_ready(host_req_ready),
		.host_rsp_valid(host_rsp_valid),
		.host_rsp(host_rsp),
		.clk_div(clk_div),
		.reg_addr(reg_addr),
		.reg_din(reg_din),
		.reg_rd(reg_rd),
		.reg_wr(reg_wr),
		.reg_ms(reg_ms),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata)
	);

	lookup_engine #(
		.DEPTH_NBITS(DEPTH_NBITS),
		.WIDTH(WIDTH),
		.LKP_CREDITS(LKP_CREDITS)
	) u_engine (
		.clk(clk),
		.rst_n(rst_n),
		.lkp_req_valid(lkp_req_valid),
		.lkp_req(lkp_req),
		.lkp_credit(lkp_credit),
		.lkp_rsp_valid(lkp_rsp_valid),
		.lkp_rsp(lkp_rsp),
		.app_mem_rd(app_mem_rd),
		.addrb(addrb),
		.doutb(doutb),
		.wea(wea),
		.addra(addra),
		.dina(dina)
	);

	// Port A read data has no user here.
	pio_rw_dmem_bram #(
		.WIDTH(WIDTH),
		.DEPTH_NBITS(DEPTH_NBITS)
	) u_mem (
		.clk(clk),
		.rst_n(rst_n),
		.clk_div(clk_div),
		.reg_addr(reg_addr),
		.reg_din(reg_din),
		.reg_rd(reg_rd),
		.reg_wr(reg_wr),
		.reg_ms(reg_ms),
		.wea(wea),
		.addra(addra),
		.dina(dina),
		.douta(),
		.app_mem_rd(app_mem_rd),
		.web(web),
		.addrb(addrb),
		.dinb(dinb),
		.doutb(doutb),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata)
	);

endmodule

`default_nettype wire

//--- verilog/lookup_engine.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Packet-side lookup engine.
// Credit-controlled request FIFO, lookups read
// port B, learns byte-write port A.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module lookup_engine
	import pio_mem_pkg::*;
#(
	parameter int DEPTH_NBITS = TBL_DEPTH_NBITS,
	parameter int WIDTH = TBL_WIDTH,
	parameter int LKP_CREDITS = 4
) (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    lkp_req_valid,
	input  wire  lkp_req_t         lkp_req,
	output logic                   lkp_credit,
	output logic                   lkp_rsp_valid,
	output lkp_rsp_t               lkp_rsp,
	// Port B read.
	output logic                   app_mem_rd,
	output logic [DEPTH_NBITS-1:0] addrb,
	input  wire  [WIDTH-1:0]       doutb,
	// Port A learn write.
	output logic [3:0]             wea,
	output logic [DEPTH_NBITS-1:0] addra,
	output logic [WIDTH-1:0]       dina
);

	localparam int PTR_NBITS = (LKP_CREDITS > 1) ? $clog2(LKP_CREDITS) : 1;
	localparam int CNT_NBITS = $clog2(LKP_CREDITS + 1);

	lkp_req_t             fifo_mem [LKP_CREDITS];
	logic [PTR_NBITS-1:0] wr_ptr;
	logic [PTR_NBITS-1:0] rd_ptr;
	logic [CNT_NBITS-1:0] count;
	lkp_req_t             head;
	logic                 pop;
	logic                 rd_s1;
	tbl_index_t           idx_s1;

	// Pointer step with wrap at the FIFO depth.
	function automatic logic [PTR_NBITS-1:0] ptr_inc(input logic [PTR_NBITS-1:0] p);
		if (p == PTR_NBITS'(LKP_CREDITS - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Request FIFO.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Credits keep the sender from overfilling.
	assign head = fifo_mem[rd_ptr];
	assign pop = (count != '0);

	always_ff @(posedge clk) begin
		if (lkp_req_valid) begin
			fifo_mem[wr_ptr] <= lkp_req;
		end
	end

	// Head drives the RAM in its pop cycle.
	assign app_mem_rd = pop & ~head.learn;
	assign addrb = head.index;
	assign wea = (pop && head.learn) ? head.be : '0;
	assign addra = head.index;
	assign dina = head.data;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			lkp_credit <= 1'b0;
			rd_s1 <= 1'b0;
			lkp_rsp_valid <= 1'b0;
		end else begin
			if (lkp_req_valid) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			count <= count + CNT_NBITS'(lkp_req_valid) - CNT_NBITS'(pop);
			// One credit back per pop.
			lkp_credit <= pop;
			// Stage 1 waits on the RAM register.
			rd_s1 <= app_mem_rd;
			lkp_rsp_valid <= rd_s1;
		end
	end

	// Index rides along with the read.
	always_ff @(posedge clk) begin
		idx_s1 <= head.index;
		if (rd_s1) begin
			lkp_rsp.index <= idx_s1;
			lkp_rsp.data <= doutb;
		end
	end

endmodule

`default_nettype wire

//--- verilog/pio_host_bridge.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host to PIO bridge.
// Takes one host request at a time, decodes the
// table region, drives the PIO bus on the slow
// strobe and returns the response.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module pio_host_bridge
	import pio_mem_pkg::*;
#(
	parameter int PIO_DIV = 4
) (
	input  wire             clk,
	input  wire             rst_n,

	// Host side.
	input  wire             host_req_valid,
	input  wire  host_req_t host_req,
	output logic            host_req_ready,
	output logic            host_rsp_valid,
	output host_rsp_t       host_rsp,

	// Slow-clock strobe.
	output logic            clk_div,

	// PIO bus.
	output pio_word_t       reg_addr,
	output pio_word_t       reg_din,
	output logic            reg_rd,
	output logic            reg_wr,
	output logic            reg_ms,
	input  wire             mem_ack,
	input  wire  pio_word_t mem_rdata
);

	localparam int CNT_NBITS = (PIO_DIV > 1) ? $clog2(PIO_DIV) : 1;

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		WAIT_ACK,
		RESP
	} state_t;

	state_t               state;
	logic [CNT_NBITS-1:0] div_cnt;
	host_req_t            req_q;
	logic                 mem_ack_q;
	logic                 accept;
	logic                 in_region;
	logic                 issue;
	logic                 ack_rise;

	assign accept = (state == IDLE) & host_req_valid & host_req_ready;
	assign in_region = (host_req.addr[PIO_NBITS-1:16] == MEM_REGION);
	// Issue only on a strobe, so mem_ack has dropped from the last access.
	assign issue = (state == ISSUE) & clk_div;
	assign ack_rise = (state == WAIT_ACK) & mem_ack & ~mem_ack_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Strobe divider.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			clk_div <= 1'b0;
		end else begin
			if (div_cnt == CNT_NBITS'(PIO_DIV - 1)) begin
				div_cnt <= '0;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
			clk_div <= (div_cnt == CNT_NBITS'(PIO_DIV - 1));
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Request FSM.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			host_req_ready <= 1'b0;
			host_rsp_valid <= 1'b0;
			reg_rd <= 1'b0;
			reg_wr <= 1'b0;
			reg_ms <= 1'b0;
			mem_ack_q <= 1'b0;
		end else begin
			// Pulses by default.
			host_rsp_valid <= 1'b0;
			reg_rd <= issue & ~req_q.write;
			reg_wr <= issue & req_q.write;
			reg_ms <= issue;
			mem_ack_q <= mem_ack;
			case (state)
				IDLE: begin
					host_req_ready <= ~accept;
					if (accept) begin
						if (in_region) begin
							state <= ISSUE;
						end else begin
							// Out of region, answer at once.
							host_rsp_valid <= 1'b1;
							state <= RESP;
						end
					end
				end
				ISSUE: begin
					if (issue) begin
						state <= WAIT_ACK;
					end
				end
				WAIT_ACK: begin
					if (ack_rise) begin
						host_rsp_valid <= 1'b1;
						state <= RESP;
					end
				end
				default: begin
					host_req_ready <= 1'b1;
					state <= IDLE;
				end
			endcase
		end
	end

	// Request and response payload.
	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= host_req;
		end
		if (accept && !in_region) begin
			host_rsp.rdata <= '0;
			host_rsp.err <= 1'b1;
		end else if (ack_rise) begin
			// Writes carry no data back.
			host_rsp.rdata <= req_q.write ? '0 : mem_rdata;
			host_rsp.err <= 1'b0;
		end
		if (issue) begin
			reg_addr <= req_q.addr;
			reg_din <= req_q.wdata;
		end
	end

endmodule

`default_nettype wire

//--- verilog/pio_rw_dmem_bram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PIO accessible table memory.
// Port B is shared between application traffic
// and host accesses. Application always wins,
// a losing host access is saved and replayed.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module pio_rw_dmem_bram
	import pio_mem_pkg::*;
#(
	parameter int WIDTH = TBL_WIDTH,
	parameter int DEPTH_NBITS = TBL_DEPTH_NBITS
) (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire                    clk_div,

	// PIO register bus from the host bridge.
	input  wire  pio_word_t        reg_addr,
	input  wire  pio_word_t        reg_din,
	input  wire                    reg_rd,
	input  wire                    reg_wr,
	input  wire                    reg_ms,

	// Port A, application only.
	input  wire  [3:0]             wea,
	input  wire  [DEPTH_NBITS-1:0] addra,
	input  wire  [WIDTH-1:0]       dina,
	output logic [WIDTH-1:0]       douta,

	// Port B, application side.
	input  wire                    app_mem_rd,
	input  wire  [3:0]             web,
	input  wire  [DEPTH_NBITS-1:0] addrb,
	input  wire  [WIDTH-1:0]       dinb,
	output logic [WIDTH-1:0]       doutb,

	// Host completion.
	output logic                   mem_ack,
	output pio_word_t              mem_rdata
);

	logic                   host_rd;
	logic                   host_wr;
	logic                   app_mem_wr;
	logic                   app_busy;
	logic                   rd_go;
	logic                   wr_go;
	logic                   rd_save;
	logic                   wr_save;
	logic                   rd_go_d1;
	logic                   ack_int;
	logic [DEPTH_NBITS-1:0] host_addr;
	logic [3:0]             ram_web;
	logic [DEPTH_NBITS-1:0] ram_addrb;
	logic [WIDTH-1:0]       ram_dinb;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Port B arbitration.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Host strobes only count with the region select.
	assign host_rd = reg_ms & reg_rd;
	assign host_wr = reg_ms & reg_wr;

	assign app_mem_wr = |web;
	assign app_busy = app_mem_rd | app_mem_wr;

	// Host goes when port B is free, fresh or replayed.
	assign rd_go = ~app_busy & (host_rd | rd_save);
	assign wr_go = ~app_busy & (host_wr | wr_save);

	// Word address, byte offset dropped.
	assign host_addr = reg_addr[DEPTH_NBITS+1:2];

	// Host writes are always full words.
	assign ram_web = app_mem_wr ? web : {4{wr_go}};
	assign ram_addrb = app_busy ? addrb : host_addr;
	assign ram_dinb = app_mem_wr ? dinb : reg_din[WIDTH-1:0];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Save flags and acknowledge.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_save <= 1'b0;
			wr_save <= 1'b0;
			rd_go_d1 <= 1'b0;
			ack_int <= 1'b0;
			mem_ack <= 1'b0;
		end else begin
			// Collision parks the access until port B frees up.
			if (host_rd && !rd_go) begin
				rd_save <= 1'b1;
			end else if (rd_go) begin
				rd_save <= 1'b0;
			end
			if (host_wr && !wr_go) begin
				wr_save <= 1'b1;
			end else if (wr_go) begin
				wr_save <= 1'b0;
			end

			// Read data is in doutb one cycle after issue.
			rd_go_d1 <= rd_go;

			// Set wins over the strobe clear.
			if (wr_go || rd_go_d1) begin
				ack_int <= 1'b1;
			end else if (clk_div) begin
				ack_int <= 1'b0;
			end

			// Slow-side ack, moves only on the strobe.
			if (clk_div) begin
				mem_ack <= ack_int;
			end
		end
	end

	// Capture host read data, held until the next host read.
	always_ff @(posedge clk) begin
		if (rd_go_d1) begin
			mem_rdata <= PIO_NBITS'(doutb);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Memory.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	ram_dual_we_bram #(
		.WIDTH(WIDTH),
		.DEPTH_NBITS(DEPTH_NBITS)
	) u_ram (
		.clk(clk),
		.wea(wea),
		.addra(addra),
		.dina(dina),
		.douta(douta),
		.web(ram_web),
		.addrb(ram_addrb),
		.dinb(ram_dinb),
		.doutb(doutb)
	);

endmodule

`default_nettype wire

//--- verilog/ram_dual_we_bram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// True dual-port block RAM.
// Four write lanes per port, registered read
// data on both ports, one cycle of latency.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module ram_dual_we_bram #(
	parameter int WIDTH = 32,
	parameter int DEPTH_NBITS = 10
) (
	input  wire                    clk,

	// Port A.
	input  wire  [3:0]             wea,
	input  wire  [DEPTH_NBITS-1:0] addra,
	input  wire  [WIDTH-1:0]       dina,
	output logic [WIDTH-1:0]       douta,

	// Port B.
	input  wire  [3:0]             web,
	input  wire  [DEPTH_NBITS-1:0] addrb,
	input  wire  [WIDTH-1:0]       dinb,
	output logic [WIDTH-1:0]       doutb
);

	// Width of one write lane.
	localparam int LANE = WIDTH / 4;

	logic [WIDTH-1:0] mem [0:(1<<DEPTH_NBITS)-1];

	// Both ports in one process.
	// Port B lands last on a same-address collision.
	// Reads return the old word (read-first).
	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			if (wea[i]) begin
				mem[addra][i*LANE +: LANE] <= dina[i*LANE +: LANE];
			end
		end
		for (int i = 0; i < 4; i++) begin
			if (web[i]) begin
				mem[addrb][i*LANE +: LANE] <= dinb[i*LANE +: LANE];
			end
		end
		douta <= mem[addra];
		doutb <= mem[addrb];
	end

endmodule

`default_nettype wire

//--- verilog/pio_mem_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PIO lookup table package.
// Widths, vector types and request and response
// structs shared by the host bridge, the lookup
// engine and the table memory.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package pio_mem_pkg;

	// PIO bus width for both address and data.
	localparam int PIO_NBITS = 32;

	// Table entry width and index width.
	localparam int TBL_WIDTH = 32;
	localparam int TBL_DEPTH_NBITS = 10;

	// Address bits 31..16 that select the table.
	localparam logic [15:0] MEM_REGION = 16'h0001;

	typedef logic [PIO_NBITS-1:0] pio_word_t;
	typedef logic [TBL_WIDTH-1:0] tbl_data_t;
	typedef logic [TBL_DEPTH_NBITS-1:0] tbl_index_t;
	// One enable bit per byte lane.
	typedef logic [TBL_WIDTH/8-1:0] tbl_be_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Host side.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef struct packed {
		pio_word_t addr;
		pio_word_t wdata;
		logic      write;
	} host_req_t;

	// Err marks an access outside the table region.
	typedef struct packed {
		pio_word_t rdata;
		logic      err;
	} host_rsp_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Lookup side.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Learn set means a byte write, clear means a lookup.
	typedef struct packed {
		tbl_index_t index;
		logic       learn;
		tbl_data_t  data;
		tbl_be_t    be;
	} lkp_req_t;

	typedef struct packed {
		tbl_index_t index;
		tbl_data_t  data;
	} lkp_rsp_t;

endpackage

`default_nettype wire
